/* src/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// ************************************************************
// Datapath and transport dimensions.
// ************************************************************

// Data word width.
`define EXEC_XLEN 32

// Request queue slots, equal to the upstream credits after reset.
`define EXEC_REQ_DEPTH 4

// Most result credits the consumer may grant at once.
`define EXEC_RES_CREDITS 2

// Request tag width.
`define EXEC_TAG_BITS 4

`endif

/* src/isa_pkg.sv */
`default_nettype none

`include "exec_settings.svh"

package isa_pkg;

   typedef logic [`EXEC_XLEN-1:0] word_t;
   typedef logic [4:0]            shamt_t;

   // ************************************************************
   // Operations handled by the execute stage.
   // ************************************************************
   typedef enum logic [5:0] {
      // Integer and logic.
      ADD, ADDI, SUB,
      AND, ANDI, OR, ORI, XOR, XORI,
      // Shifts.
      SLL, SLLI, SRL, SRLI, SRA, SRAI,
      // Set less than.
      SLT, SLTI, SLTU, SLTIU,
      // Upper immediate and jumps.
      LUI, AUIPC, JAL, JALR,
      // Loads and stores, address only.
      LB, LH, LW, LBU, LHU,
      SB, SH, SW,
      // RV32M.
      MUL, MULH, MULHSU, MULHU,
      DIV, DIVU, REM, REMU
   } exec_op_e;

endpackage

`default_nettype wire

/* src/exec_flow_pkg.sv */
`default_nettype none

`include "exec_settings.svh"

package exec_flow_pkg;

   import isa_pkg::*;

   typedef logic [`EXEC_TAG_BITS-1:0] tag_t;
   typedef logic [2:0]                credit_t;

   // Request from the decode stage.
   typedef struct packed {
      tag_t     tag;
      exec_op_e op;
      word_t    rs1;
      word_t    rs2;
      word_t    imm;
      word_t    pc;
   } exec_req_t;

   // Result toward the consumer. Target is zero unless redirect.
   typedef struct packed {
      tag_t  tag;
      word_t value;
      word_t target;
      logic  redirect;
      logic  eq;
      logic  gtu;
   } exec_res_t;

endpackage

`default_nettype wire

/* src/exec_req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module exec_req_queue
   import exec_flow_pkg::*;
#(
   parameter int DEPTH = `EXEC_REQ_DEPTH
) (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      push_i,
   input  exec_req_t push_data_i,
   input  logic      pop_i,
   output logic      head_valid_o,
   output exec_req_t head_o,
   output logic      credit_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   typedef logic [PTR_W-1:0] ptr_t;

   exec_req_t        mem_q [DEPTH];
   ptr_t             wr_ptr_q;
   ptr_t             rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             credit_q;
   logic             do_pop;

   function automatic ptr_t next_ptr(ptr_t p);
      return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
   endfunction

   assign head_valid_o = (count_q != '0);
   assign head_o       = mem_q[rd_ptr_q];
   assign do_pop       = pop_i && head_valid_o;
   assign credit_o     = credit_q;

   // Upstream credits keep a push from landing on a full queue.
   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         credit_q <= 1'b0;
      end else begin
         credit_q <= do_pop;
         if (push_i) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         case ({push_i, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu
   import isa_pkg::*, exec_flow_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      start_i,
   input  exec_req_t req_i,
   output logic      done_o,
   output exec_res_t res_o
);

   word_t     rs1;
   word_t     rs2;
   word_t     imm;
   word_t     upper_imm;
   shamt_t    sh_reg;
   shamt_t    sh_imm;
   exec_res_t res_d;
   exec_res_t res_q;
   logic      done_q;

   assign rs1       = req_i.rs1;
   assign rs2       = req_i.rs2;
   assign imm       = req_i.imm;
   assign sh_reg    = rs2[4:0];
   assign sh_imm    = imm[4:0];
   assign upper_imm = word_t'({imm[19:0], 12'h000});

   // ************************************************************
   // Result selection.
   // ************************************************************
   always_comb begin
      res_d     = '0;
      res_d.tag = req_i.tag;
      res_d.eq  = (rs1 == rs2);
      res_d.gtu = (rs1 > rs2);
      case (req_i.op)
         ADD:   res_d.value = rs1 + rs2;
         ADDI:  res_d.value = rs1 + imm;
         SUB:   res_d.value = rs1 - rs2;
         AND:   res_d.value = rs1 & rs2;
         ANDI:  res_d.value = rs1 & imm;
         OR:    res_d.value = rs1 | rs2;
         ORI:   res_d.value = rs1 | imm;
         XOR:   res_d.value = rs1 ^ rs2;
         XORI:  res_d.value = rs1 ^ imm;
         SLL:   res_d.value = rs1 << sh_reg;
         SLLI:  res_d.value = rs1 << sh_imm;
         SRL:   res_d.value = rs1 >> sh_reg;
         SRLI:  res_d.value = rs1 >> sh_imm;
         SRA:   res_d.value = $signed(rs1) >>> sh_reg;
         SRAI:  res_d.value = $signed(rs1) >>> sh_imm;
         SLT:   res_d.value = word_t'($signed(rs1) < $signed(rs2));
         SLTI:  res_d.value = word_t'($signed(rs1) < $signed(imm));
         SLTU:  res_d.value = word_t'(rs1 < rs2);
         SLTIU: res_d.value = word_t'(rs1 < imm);
         LUI:   res_d.value = upper_imm;
         AUIPC: res_d.value = req_i.pc + upper_imm;
         JAL: begin
            res_d.value    = req_i.pc + word_t'(4);
            res_d.target   = req_i.pc + imm;
            res_d.redirect = 1'b1;
         end
         JALR: begin
            res_d.value    = req_i.pc + word_t'(4);
            res_d.target   = rs1 + imm;
            res_d.redirect = 1'b1;
         end
         // Address sum only.
         LB, LH, LW, LBU, LHU, SB, SH, SW: res_d.value = rs1 + imm;
         default: res_d.value = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= start_i;
      end
      if (start_i) begin
         res_q <= res_d;
      end
   end

   assign done_o = done_q;
   assign res_o  = res_q;

endmodule

`default_nettype wire

/* src/exec_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module exec_muldiv
   import isa_pkg::*, exec_flow_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      start_i,
   input  exec_req_t req_i,
   output logic      done_o,
   output exec_res_t res_o
);

   localparam int XLEN = `EXEC_XLEN;

   typedef enum logic [1:0] {S_IDLE, S_RUN, S_FINISH} md_state_e;

   md_state_e                  state_q;
   shamt_t                     count_q;
   logic                       done_q;
   exec_res_t                  res_q;
   exec_res_t                  mul_res;
   exec_res_t                  fin_res;
   logic                       is_div;
   logic                       is_rem;
   logic                       div_signed;
   logic                       div_zero;
   logic                       special;
   word_t                      special_val;
   word_t                      mag_a;
   word_t                      mag_b;
   logic signed [XLEN:0]       ext_a;
   logic signed [XLEN:0]       ext_b;
   logic signed [2*XLEN+1:0]   product;
   word_t                      rem_q;
   word_t                      quo_q;
   word_t                      dvs_q;
   word_t                      quo_fix;
   word_t                      rem_fix;
   word_t                      special_val_q;
   logic                       special_q;
   logic                       is_rem_q;
   logic                       neg_quo_q;
   logic                       neg_rem_q;
   tag_t                       tag_q;
   logic                       eq_q;
   logic                       gtu_q;

   // One restoring step. Returns the new remainder and quotient.
   function automatic logic [2*XLEN-1:0] div_step(word_t rem, word_t quo, word_t dvs);
      logic [XLEN:0] shifted;
      logic [XLEN:0] diff;
      shifted = {rem, quo[XLEN-1]};
      diff    = shifted - {1'b0, dvs};
      if (shifted >= {1'b0, dvs}) begin
         return {diff[XLEN-1:0], quo[XLEN-2:0], 1'b1};
      end
      return {shifted[XLEN-1:0], quo[XLEN-2:0], 1'b0};
   endfunction

   // ************************************************************
   // Multiply, one shared signed 33x33 product.
   // ************************************************************
   assign ext_a   = {(req_i.op inside {MULH, MULHSU}) & req_i.rs1[XLEN-1], req_i.rs1};
   assign ext_b   = {(req_i.op == MULH) & req_i.rs2[XLEN-1], req_i.rs2};
   assign product = ext_a * ext_b;

   always_comb begin
      mul_res       = '0;
      mul_res.tag   = req_i.tag;
      mul_res.eq    = (req_i.rs1 == req_i.rs2);
      mul_res.gtu   = (req_i.rs1 > req_i.rs2);
      mul_res.value = (req_i.op == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
   end

   // ************************************************************
   // Divide setup and sign fix.
   // ************************************************************
   assign is_div     = req_i.op inside {DIV, DIVU, REM, REMU};
   assign is_rem     = req_i.op inside {REM, REMU};
   assign div_signed = req_i.op inside {DIV, REM};
   assign div_zero   = (req_i.rs2 == '0);
   assign special    = div_zero || (div_signed && req_i.rs2 == '1 &&
                                    req_i.rs1 == {1'b1, {(XLEN-1){1'b0}}});
   assign special_val = is_rem ? (div_zero ? req_i.rs1 : '0) : (div_zero ? '1 : req_i.rs1);
   assign mag_a = (div_signed && req_i.rs1[XLEN-1]) ? -req_i.rs1 : req_i.rs1;
   assign mag_b = (div_signed && req_i.rs2[XLEN-1]) ? -req_i.rs2 : req_i.rs2;

   assign quo_fix = neg_quo_q ? -quo_q : quo_q;
   assign rem_fix = neg_rem_q ? -rem_q : rem_q;

   always_comb begin
      fin_res       = '0;
      fin_res.tag   = tag_q;
      fin_res.eq    = eq_q;
      fin_res.gtu   = gtu_q;
      fin_res.value = special_q ? special_val_q : (is_rem_q ? rem_fix : quo_fix);
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         count_q <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (start_i && !is_div) begin
                  done_q <= 1'b1;
               end else if (start_i) begin
                  // The first step runs in the start cycle.
                  count_q <= shamt_t'(1);
                  state_q <= special ? S_FINISH : S_RUN;
               end
            end
            S_RUN: begin
               count_q <= count_q + 1'b1;
               if (count_q == shamt_t'(XLEN - 1)) begin
                  state_q <= S_FINISH;
               end
            end
            default: begin
               done_q  <= 1'b1;
               state_q <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && start_i) begin
         res_q          <= mul_res;
         tag_q          <= req_i.tag;
         eq_q           <= mul_res.eq;
         gtu_q          <= mul_res.gtu;
         is_rem_q       <= is_rem;
         special_q      <= special;
         special_val_q  <= special_val;
         neg_quo_q      <= div_signed && (req_i.rs1[XLEN-1] ^ req_i.rs2[XLEN-1]);
         neg_rem_q      <= div_signed && req_i.rs1[XLEN-1];
         dvs_q          <= mag_b;
         {rem_q, quo_q} <= div_step('0, mag_a, mag_b);
      end else if (state_q == S_RUN) begin
         {rem_q, quo_q} <= div_step(rem_q, quo_q, dvs_q);
      end else if (state_q == S_FINISH) begin
         res_q <= fin_res;
      end
   end

   assign done_o = done_q;
   assign res_o  = res_q;

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module exec_unit
   import isa_pkg::*, exec_flow_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      req_valid_i,
   input  exec_req_t req_i,
   output logic      req_credit_o,
   output logic      res_valid_o,
   output exec_res_t res_o,
   input  logic      res_credit_i
);

   typedef enum logic [1:0] {S_IDLE, S_BUSY, S_HOLD} seq_state_e;

   seq_state_e state_q;
   credit_t    credit_q;
   exec_req_t  head;
   logic       head_valid;
   logic       pop;
   logic       is_md;
   logic       alu_start;
   logic       md_start;
   logic       alu_done;
   logic       md_done;
   logic       unit_done;
   logic       has_credit;
   exec_res_t  alu_res;
   exec_res_t  md_res;
   exec_res_t  unit_res;
   exec_res_t  hold_q;

   exec_req_queue #(.DEPTH(`EXEC_REQ_DEPTH)) i_req_queue (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .push_i       (req_valid_i),
      .push_data_i  (req_i),
      .pop_i        (pop),
      .head_valid_o (head_valid),
      .head_o       (head),
      .credit_o     (req_credit_o)
   );

   exec_alu i_alu (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .start_i (alu_start),
      .req_i   (head),
      .done_o  (alu_done),
      .res_o   (alu_res)
   );

   exec_muldiv i_muldiv (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .start_i (md_start),
      .req_i   (head),
      .done_o  (md_done),
      .res_o   (md_res)
   );

   // ************************************************************
   // Sequencer. One operation in flight past the queue.
   // ************************************************************
   assign is_md      = head.op inside {MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
   assign pop        = (state_q == S_IDLE) && head_valid;
   assign alu_start  = pop && !is_md;
   assign md_start   = pop && is_md;
   assign unit_done  = alu_done || md_done;
   assign unit_res   = md_done ? md_res : alu_res;
   assign has_credit = (credit_q != '0);

   assign res_valid_o = has_credit && ((state_q == S_BUSY && unit_done) || state_q == S_HOLD);
   assign res_o       = (state_q == S_HOLD) ? hold_q : unit_res;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q  <= S_IDLE;
         credit_q <= '0;
      end else begin
         credit_q <= credit_q + credit_t'(res_credit_i) - credit_t'(res_valid_o);
         case (state_q)
            S_IDLE: if (pop) state_q <= S_BUSY;
            S_BUSY: if (unit_done) state_q <= has_credit ? S_IDLE : S_HOLD;
            default: if (has_credit) state_q <= S_IDLE;
         endcase
      end
   end

   // No credit yet, so park the result.
   always_ff @(posedge clk_i) begin
      if (state_q == S_BUSY && unit_done && !has_credit) begin
         hold_q <= unit_res;
      end
   end

endmodule

`default_nettype wire

/* verification/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Expected result of one request, worked out from the RV32IM rules.
function automatic exec_res_t exec_model(input exec_req_t r);
   exec_res_t res;
   word_t     opb;
   word_t     upper;
   longint    a_s;
   longint    b_s;
   longint    a_z;
   longint    b_z;
   longint    prod;
   int        sh;
   res     = '0;
   res.tag = r.tag;
   res.eq  = (r.rs1 == r.rs2);
   res.gtu = (r.rs1 > r.rs2);
   // Immediate forms take imm as the second operand.
   opb   = (r.op inside {ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU}) ? r.imm : r.rs2;
   upper = r.imm << 12;
   a_s   = longint'($signed(r.rs1));
   b_s   = longint'($signed(opb));
   a_z   = longint'(r.rs1);
   b_z   = longint'(opb);
   sh    = int'(opb[4:0]);
   case (r.op)
      ADD, ADDI:   res.value = word_t'(a_s + b_s);
      SUB:         res.value = word_t'(a_s - b_s);
      AND, ANDI:   res.value = r.rs1 & opb;
      OR, ORI:     res.value = r.rs1 | opb;
      XOR, XORI:   res.value = r.rs1 ^ opb;
      SLL, SLLI:   res.value = word_t'(a_z << sh);
      SRL, SRLI:   res.value = word_t'(a_z >> sh);
      SRA, SRAI:   res.value = word_t'(a_s >>> sh);
      SLT, SLTI:   res.value = (a_s < b_s) ? 32'd1 : 32'd0;
      SLTU, SLTIU: res.value = (a_z < b_z) ? 32'd1 : 32'd0;
      LUI:         res.value = upper;
      AUIPC:       res.value = r.pc + upper;
      JAL, JALR: begin
         res.value    = r.pc + 32'd4;
         res.target   = (r.op == JAL) ? r.pc + r.imm : r.rs1 + r.imm;
         res.redirect = 1'b1;
      end
      LB, LH, LW, LBU, LHU, SB, SH, SW: res.value = r.rs1 + r.imm;
      MUL:    res.value = word_t'(a_s * b_s);
      MULH:   res.value = word_t'((a_s * b_s) >> 32);
      MULHSU: res.value = word_t'((a_s * b_z) >> 32);
      MULHU: begin
         prod      = a_z * b_z;
         res.value = word_t'(prod >> 32);
      end
      // 64-bit quotient of MIN / -1 truncates back to MIN, remainder 0.
      DIV:    res.value = (r.rs2 == '0) ? '1 : word_t'(a_s / b_s);
      DIVU:   res.value = (r.rs2 == '0) ? '1 : word_t'(a_z / b_z);
      REM:    res.value = (r.rs2 == '0) ? r.rs1 : word_t'(a_s % b_s);
      REMU:   res.value = (r.rs2 == '0) ? r.rs1 : word_t'(a_z % b_z);
      default: res.value = '0;
   endcase
   return res;
endfunction

`endif

/* verification/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module exec_tb
   import isa_pkg::*, exec_flow_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   localparam int SEED       = 44264;
   localparam int MIX_LEN    = 24;
   localparam int STALL_LEN  = 8;
   localparam int TOTAL_REQS = 19 * 5 + 6 * 2 + 12 * 4 + 4 * 9 + 4 * 6 + MIX_LEN + STALL_LEN;

   logic      clk = 1'b0;
   logic      rst;
   logic      req_valid;
   exec_req_t req;
   logic      req_credit;
   logic      res_valid;
   exec_res_t res;
   logic      res_credit;
   logic      grant_en;

   integer    seed = SEED;
   integer    credit_seed = SEED;
   tag_t      next_tag = '0;
   int        sent_count = 0;
   int        returned_count = 0;
   int        granted_count = 0;
   int        used_count = 0;
   int        rcv_count = 0;
   exec_req_t stim_q[$];
   string     stim_name_q[$];
   exec_res_t exp_q[$];

   `include "exec_model.svh"

   exec_unit i_exec_unit (
      .clk_i        (clk),
      .rst_i        (rst),
      .req_valid_i  (req_valid),
      .req_i        (req),
      .req_credit_o (req_credit),
      .res_valid_o  (res_valid),
      .res_o        (res),
      .res_credit_i (res_credit)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   // ************************************************************
   // Compare tasks.
   // ************************************************************
   task automatic check_word(input string name, input string field, input word_t exp,
                             input word_t act);
      if (exp !== act) begin
         abort_run($sformatf("MISMATCH %s %s: expected 0x%h, actual 0x%h", name, field, exp, act));
      end
   endtask

   task automatic check_tag(input string name, input tag_t exp, input tag_t act);
      if (exp !== act) begin
         abort_run($sformatf("MISMATCH %s tag: expected 0x%h, actual 0x%h", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input string field, input logic exp,
                             input logic act);
      if (exp !== act) begin
         abort_run($sformatf("MISMATCH %s %s: expected %b, actual %b", name, field, exp, act));
      end
   endtask

   task automatic compare_result(input string name, input exec_res_t exp, input exec_res_t act);
      check_tag(name, exp.tag, act.tag);
      check_word(name, "value", exp.value, act.value);
      check_word(name, "target", exp.target, act.target);
      check_flag(name, "redirect", exp.redirect, act.redirect);
      check_flag(name, "eq", exp.eq, act.eq);
      check_flag(name, "gtu", exp.gtu, act.gtu);
   endtask

   // ************************************************************
   // Stimulus helpers.
   // ************************************************************
   function automatic word_t rand_word();
      return word_t'($random(seed));
   endfunction

   // Sign-extended 12-bit value.
   function automatic word_t rand_imm12();
      word_t w;
      w = rand_word();
      return word_t'($signed(w) >>> 20);
   endfunction

   function automatic word_t extreme(input int j);
      case (j % 4)
         0:       return 32'h8000_0000;
         1:       return 32'hffff_ffff;
         2:       return 32'h7fff_ffff;
         default: return 32'h0000_0001;
      endcase
   endfunction

   task automatic add_req(input string name, input exec_op_e op, input word_t rs1,
                          input word_t rs2, input word_t imm);
      exec_req_t r;
      r.tag    = next_tag;
      r.op     = op;
      r.rs1    = rs1;
      r.rs2    = rs2;
      r.imm    = imm;
      r.pc     = rand_word() & 32'hffff_fffc;
      next_tag = next_tag + 1'b1;
      stim_q.push_back(r);
      stim_name_q.push_back($sformatf("%s/%s", name, op.name()));
   endtask

   task automatic wait_results();
      while (rcv_count < stim_q.size()) begin
         @(posedge clk);
      end
   endtask

   // Upstream driver with its own credit count.
   initial begin
      req_valid = 1'b0;
      req       = '0;
      forever begin
         @(posedge clk);
         #1;
         if (!rst && sent_count < stim_q.size() &&
             sent_count - returned_count < `EXEC_REQ_DEPTH) begin
            req       = stim_q[sent_count];
            req_valid = 1'b1;
            exp_q.push_back(exec_model(stim_q[sent_count]));
            sent_count++;
         end else begin
            req_valid = 1'b0;
         end
      end
   end

   // Result credits, sometimes held back.
   initial begin
      res_credit = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (grant_en && granted_count - used_count < `EXEC_RES_CREDITS &&
             ($random(credit_seed) & 3) != 0) begin
            res_credit = 1'b1;
            granted_count++;
         end else begin
            res_credit = 1'b0;
         end
      end
   end

   // Compare process, sampling mid-cycle.
   always @(negedge clk) begin
      if (!rst) begin
         if (req_credit) begin
            if (returned_count >= sent_count) begin
               abort_run("upstream credit returned with no request in the queue");
            end
            returned_count++;
         end
         if (res_valid) begin
            if (granted_count == used_count) begin
               abort_run("result sent without a result credit");
            end
            if (rcv_count >= exp_q.size()) begin
               abort_run("result arrived with no request pending");
            end
            compare_result(stim_name_q[rcv_count], exp_q[rcv_count], res);
            used_count++;
            rcv_count++;
         end
      end
   end

   initial begin
      repeat (TOTAL_REQS * 40 + 500) @(posedge clk);
      abort_run("results stopped arriving before the tests finished");
   end

   // ************************************************************
   // Tests.
   // ************************************************************
   task automatic check_reset_state();
      repeat (6) begin
         @(negedge clk);
         if (res_valid !== 1'b0 || req_credit !== 1'b0) begin
            abort_run("outputs active after reset with no request and no credit");
         end
      end
      grant_en = 1'b1;
      repeat (5) @(posedge clk);
   endtask

   task automatic run_alu_tests();
      exec_op_e op;
      word_t    w;
      for (int i = int'(ADD); i <= int'(SLTIU); i++) begin
         op = exec_op_e'(i);
         repeat (4) add_req("alu_random", op, rand_word(), rand_word(), rand_imm12());
         w = rand_word();
         add_req("alu_equal", op, w, w, rand_imm12());
         if (op inside {SLL, SLLI, SRL, SRLI, SRA, SRAI}) begin
            add_req("shift_by_0", op, rand_word() | 32'h8000_0000, 32'h0, 32'h0);
            add_req("shift_by_31", op, rand_word() | 32'h8000_0000, 32'h1f, 32'h1f);
         end
      end
      wait_results();
   endtask

   task automatic run_addr_jump_tests();
      exec_op_e op;
      word_t    w;
      for (int i = int'(LUI); i <= int'(SW); i++) begin
         op = exec_op_e'(i);
         repeat (3) add_req("addr_jump", op, rand_word(), rand_word(), rand_imm12());
         w = rand_word();
         add_req("addr_jump_equal", op, w, w, rand_imm12());
      end
      wait_results();
   endtask

   task automatic run_muldiv_tests();
      exec_op_e op;
      for (int i = int'(MUL); i <= int'(MULHU); i++) begin
         op = exec_op_e'(i);
         for (int j = 0; j < 4; j++) begin
            add_req("mul_extremes", op, extreme(j), extreme(j), '0);
            add_req("mul_extremes", op, extreme(j), extreme(j + 1), '0);
         end
         add_req("mul_random", op, rand_word(), rand_word(), '0);
      end
      for (int i = int'(DIV); i <= int'(REMU); i++) begin
         op = exec_op_e'(i);
         repeat (3) add_req("div_random", op, rand_word(), rand_word(), '0);
         add_req("div_small_divisor", op, rand_word(), rand_imm12(), '0);
         add_req("div_by_zero", op, rand_word(), '0, '0);
         add_req("div_overflow", op, 32'h8000_0000, 32'hffff_ffff, '0);
      end
      wait_results();
   endtask

   // Divides interleaved with single-cycle operations.
   task automatic run_order_test();
      exec_op_e op;
      for (int k = 0; k < MIX_LEN; k++) begin
         op = (k % 3 == 0) ? exec_op_e'(int'(DIV) + k % 4) : exec_op_e'(k % 23);
         add_req("mixed_order", op, rand_word(), rand_word(), rand_imm12());
      end
      wait_results();
   endtask

   task automatic run_credit_test();
      int got;
      int back;
      grant_en = 1'b0;
      for (int k = 0; k < STALL_LEN; k++) begin
         add_req("credit_stall", exec_op_e'(k % 19), rand_word(), rand_word(), rand_imm12());
      end
      repeat (60) @(posedge clk);
      got  = rcv_count;
      back = returned_count;
      repeat (40) @(posedge clk);
      if (rcv_count != got) begin
         abort_run("results kept arriving with result credits withheld");
      end
      if (returned_count != back) begin
         abort_run("upstream credits kept returning after the queue filled");
      end
      if (sent_count - returned_count != `EXEC_REQ_DEPTH) begin
         abort_run("request queue did not fill while results were blocked");
      end
      grant_en = 1'b1;
      wait_results();
      repeat (4) @(posedge clk);
      if (returned_count != sent_count) begin
         abort_run("upstream credits returned do not match requests sent");
      end
   endtask

   initial begin
      rst      = 1'b1;
      grant_en = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      check_reset_state();
      run_alu_tests();
      run_addr_jump_tests();
      run_muldiv_tests();
      run_order_test();
      run_credit_test();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
+incdir+verification
src/isa_pkg.sv
src/exec_flow_pkg.sv
src/exec_req_queue.sv
src/exec_alu.sv
src/exec_muldiv.sv
src/exec_unit.sv
verification/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= ALL TESTS PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh verification/*.sv verification/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
